// File: Makefile
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 -f build.f --top-module pc_guard_tb -o sim_pc_guard

run: build
	./obj_dir/sim_pc_guard > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

lint:
	verilator --lint-only --timing -f build.f --top-module pc_guard_tb

clean:
	rm -rf obj_dir $(LOG)

// File: build.f
+incdir+include
rtl/pc_guard_pkg.sv
rtl/pc_ctrl_fsm.sv
rtl/pc_gen.sv
rtl/pc_check.sv
rtl/pc_err_counter.sv
rtl/pc_guard_apb.sv
rtl/pc_guard_top.sv
tests/tb_clk_gen.sv
tests/pc_guard_tb.sv

// File: include/pc_guard_consts.svh
// PC guard constants for widths, APB register offsets and reset values
`ifndef PC_GUARD_CONSTS_SVH
`define PC_GUARD_CONSTS_SVH

// Datapath widths
`define PC_GUARD_ADDR_W  32
`define PC_GUARD_CNT_W   8
`define PC_GUARD_PADDR_W 8
`define PC_GUARD_DATA_W  32

// APB register map, byte offsets
`define PC_GUARD_REG_CTRL   8'h00
`define PC_GUARD_REG_BOOT   8'h04
`define PC_GUARD_REG_TRAP   8'h08
`define PC_GUARD_REG_THRESH 8'h0C
`define PC_GUARD_REG_COUNT  8'h10
`define PC_GUARD_REG_STATUS 8'h14

// Register reset values
`define PC_GUARD_BOOT_RST   32'h0000_0080
`define PC_GUARD_TRAP_RST   32'h0000_0100
`define PC_GUARD_THRESH_RST 8'd4

`endif

// File: rtl/pc_check.sv
// Independent PC checker recomputing the expected fetch PC and control-flow decisions
`timescale 1ns/1ps
`include "pc_guard_consts.svh"

module pc_check (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      check_en_i,
  input  logic                      accept_i,
  input  logic                      instr_compressed_i,
  input  logic                      pc_set_i,
  input  pc_guard_pkg::instr_kind_e instr_kind_i,
  input  logic                      instr_taken_i,
  input  pc_guard_pkg::pc_mux_e     pc_mux_i,
  input  pc_guard_pkg::pc_t         instr_target_i,
  input  pc_guard_pkg::pc_t         boot_addr_i,
  input  pc_guard_pkg::pc_t         trap_addr_i,
  input  pc_guard_pkg::pc_t         pc_i,
  output logic                      pc_err_o
);

  // Flopped copy of the last request
  logic                  pc_set_q;
  pc_guard_pkg::pc_mux_e pc_mux_q;
  logic                  accept_q;
  logic                  compressed_q;
  pc_guard_pkg::pc_t     pc_prev_q;
  pc_guard_pkg::pc_t     target_q;
  logic                  compare_enable_q;

  pc_guard_pkg::pc_t     incr_addr;
  pc_guard_pkg::pc_t     flow_addr;
  pc_guard_pkg::pc_t     check_addr;
  logic                  addr_err;
  logic                  need_set;
  logic                  flow_set;
  logic                  decision_err;

  //////////////////////////////////////////////////////////////////////
  // Address check
  //////////////////////////////////////////////////////////////////////

  // Sequential successor of the PC seen at accept
  assign incr_addr = pc_prev_q + (compressed_q ? pc_guard_pkg::pc_t'(2) :
                                                 pc_guard_pkg::pc_t'(4));

  // Non-sequential target from the flopped mux value
  always_comb begin
    case (pc_mux_q)
      pc_guard_pkg::PC_JUMP:   flow_addr = target_q;
      pc_guard_pkg::PC_BRANCH: flow_addr = target_q;
      pc_guard_pkg::PC_TRAP:   flow_addr = trap_addr_i;
      default:                 flow_addr = boot_addr_i;
    endcase
  end

  assign check_addr = pc_set_q ? {flow_addr[`PC_GUARD_ADDR_W-1:1], 1'b0} : incr_addr;

  // Only meaningful the cycle after a set or an accept
  assign addr_err = (pc_set_q || accept_q) && (check_addr != pc_i);

  //////////////////////////////////////////////////////////////////////
  // Decision check
  //////////////////////////////////////////////////////////////////////

  // Jumps and taken branches must redirect
  assign need_set = (instr_kind_i == pc_guard_pkg::KIND_JUMP) ||
                    ((instr_kind_i == pc_guard_pkg::KIND_BRANCH) && instr_taken_i);

  // Set caused by an instruction and not by boot or trap
  assign flow_set = pc_set_i && ((pc_mux_i == pc_guard_pkg::PC_JUMP) ||
                                 (pc_mux_i == pc_guard_pkg::PC_BRANCH));

  // A flow set with no instruction behind it is wrong too
  assign decision_err = accept_i ? (need_set != flow_set) : flow_set;

  //////////////////////////////////////////////////////////////////////
  // Flops
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_set_q         <= 1'b0;
      pc_mux_q         <= pc_guard_pkg::PC_BOOT;
      accept_q         <= 1'b0;
      compare_enable_q <= 1'b0;
    end else begin
      pc_set_q <= pc_set_i;
      accept_q <= accept_i;
      // Sticky once the first set has been seen
      if (pc_set_i) begin
        pc_mux_q         <= pc_mux_i;
        compare_enable_q <= 1'b1;
      end
    end
  end

  // Payload of the last accepted descriptor
  always_ff @(posedge clk) begin
    if (accept_i) begin
      pc_prev_q    <= pc_i;
      compressed_q <= instr_compressed_i;
      target_q     <= instr_target_i;
    end
  end

  assign pc_err_o = (addr_err || decision_err) && compare_enable_q && check_en_i;

endmodule

// File: rtl/pc_ctrl_fsm.sv
// Controller FSM that accepts instruction descriptors and issues PC set requests
`timescale 1ns/1ps

module pc_ctrl_fsm (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      instr_valid_i,
  input  pc_guard_pkg::instr_kind_e instr_kind_i,
  input  logic                      instr_taken_i,
  input  logic                      alert_i,
  output logic                      instr_ready_o,
  output logic                      accept_o,
  output logic                      pc_set_o,
  output pc_guard_pkg::pc_mux_e     pc_mux_o
);

  pc_guard_pkg::fsm_state_e state_q;
  pc_guard_pkg::fsm_state_e state_d;

  //////////////////////////////////////////////////////////////////////
  // Next state and outputs
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    instr_ready_o = 1'b0;
    pc_set_o      = 1'b0;
    pc_mux_o      = pc_guard_pkg::PC_BOOT;

    case (state_q)
      pc_guard_pkg::ST_BOOT: begin
        // Load the boot address once, stream held off
        pc_set_o = 1'b1;
        pc_mux_o = pc_guard_pkg::PC_BOOT;
        state_d  = pc_guard_pkg::ST_RUN;
      end

      pc_guard_pkg::ST_RUN: begin
        instr_ready_o = 1'b1;
        // Jumps always redirect
        if (instr_valid_i && (instr_kind_i == pc_guard_pkg::KIND_JUMP)) begin
          pc_set_o = 1'b1;
          pc_mux_o = pc_guard_pkg::PC_JUMP;
        end
        // Branches only redirect when taken
        if (instr_valid_i && (instr_kind_i == pc_guard_pkg::KIND_BRANCH) && instr_taken_i) begin
          pc_set_o = 1'b1;
          pc_mux_o = pc_guard_pkg::PC_BRANCH;
        end
        // Alert from the error counter diverts flow to the trap handler
        if (alert_i) begin
          state_d = pc_guard_pkg::ST_TRAP;
        end
      end

      pc_guard_pkg::ST_TRAP: begin
        // One cycle of trap redirect, stream held off
        pc_set_o = 1'b1;
        pc_mux_o = pc_guard_pkg::PC_TRAP;
        state_d  = pc_guard_pkg::ST_RUN;
      end

      default: begin
        state_d = pc_guard_pkg::ST_BOOT;
      end
    endcase
  end

  // Handshake on the descriptor stream
  assign accept_o = instr_valid_i && instr_ready_o;

  //////////////////////////////////////////////////////////////////////
  // State register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= pc_guard_pkg::ST_BOOT;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// File: rtl/pc_err_counter.sv
// Saturating checker error counter with threshold compare and alert pulse
`timescale 1ns/1ps

module pc_err_counter (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   pc_err_i,
  input  logic                   clr_i,
  input  pc_guard_pkg::err_cnt_t thresh_i,
  output pc_guard_pkg::err_cnt_t count_o,
  output logic                   alert_o
);

  pc_guard_pkg::err_cnt_t count_q;
  pc_guard_pkg::err_cnt_t count_inc;
  logic                   at_max;
  logic                   alert_q;

  assign count_inc = count_q + pc_guard_pkg::err_cnt_t'(1);

  // Counter holds at all ones
  assign at_max = &count_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
      alert_q <= 1'b0;
    end else begin
      alert_q <= 1'b0;
      if (clr_i) begin
        count_q <= '0;
      end else if (pc_err_i && !at_max) begin
        count_q <= count_inc;
        // Alert only on the step onto the threshold
        alert_q <= (count_inc == thresh_i);
      end
    end
  end

  assign count_o = count_q;
  assign alert_o = alert_q;

endmodule

// File: rtl/pc_gen.sv
// Fetch PC generator with sequential increment, set source select and fault injection
`timescale 1ns/1ps
`include "pc_guard_consts.svh"

module pc_gen (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  accept_i,
  input  logic                  instr_compressed_i,
  input  logic                  pc_set_i,
  input  pc_guard_pkg::pc_mux_e pc_mux_i,
  input  pc_guard_pkg::pc_t     instr_target_i,
  input  pc_guard_pkg::pc_t     boot_addr_i,
  input  pc_guard_pkg::pc_t     trap_addr_i,
  input  logic                  inject_i,
  output pc_guard_pkg::pc_t     pc_o
);

  pc_guard_pkg::pc_t pc_q;
  pc_guard_pkg::pc_t set_addr;
  pc_guard_pkg::pc_t next_pc;
  logic              update;
  logic              corrupt;
  logic              inject_pend_q;

  // Source selected on a PC set
  always_comb begin
    case (pc_mux_i)
      pc_guard_pkg::PC_JUMP:   set_addr = instr_target_i;
      pc_guard_pkg::PC_BRANCH: set_addr = instr_target_i;
      pc_guard_pkg::PC_TRAP:   set_addr = trap_addr_i;
      default:                 set_addr = boot_addr_i;
    endcase
  end

  // Any PC change where a set wins over the sequential increment
  assign update = pc_set_i || accept_i;

  // Halfword alignment on sets and +2 or +4 on sequential steps
  assign next_pc = pc_set_i ? {set_addr[`PC_GUARD_ADDR_W-1:1], 1'b0} :
                   pc_q + (instr_compressed_i ? pc_guard_pkg::pc_t'(2) :
                                                pc_guard_pkg::pc_t'(4));

  // Self-test fault is armed by a pulse and consumed by the next update
  assign corrupt = inject_pend_q || inject_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q          <= '0;
      inject_pend_q <= 1'b0;
    end else begin
      if (update) begin
        // Flip bit 1 once when a fault is armed
        pc_q <= next_pc ^ (corrupt ? pc_guard_pkg::pc_t'(2) : '0);
      end
      if (update) begin
        inject_pend_q <= 1'b0;
      end else if (inject_i) begin
        inject_pend_q <= 1'b1;
      end
    end
  end

  assign pc_o = pc_q;

endmodule

// File: rtl/pc_guard_apb.sv
// APB register block for PC guard configuration, fault injection and status
`timescale 1ns/1ps
`include "pc_guard_consts.svh"

module pc_guard_apb (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [`PC_GUARD_PADDR_W-1:0] paddr_i,
  input  logic                         psel_i,
  input  logic                         penable_i,
  input  logic                         pwrite_i,
  input  logic [`PC_GUARD_DATA_W-1:0]  pwdata_i,
  output logic [`PC_GUARD_DATA_W-1:0]  prdata_o,
  output logic                         pready_o,
  output logic                         pslverr_o,
  input  pc_guard_pkg::err_cnt_t       count_i,
  input  logic                         pc_err_i,
  input  logic                         alert_i,
  output pc_guard_pkg::pc_t            boot_addr_o,
  output pc_guard_pkg::pc_t            trap_addr_o,
  output pc_guard_pkg::err_cnt_t       thresh_o,
  output logic                         check_en_o,
  output logic                         inject_o,
  output logic                         count_clr_o
);

  pc_guard_pkg::pc_t      boot_q;
  pc_guard_pkg::pc_t      trap_q;
  pc_guard_pkg::err_cnt_t thresh_q;
  logic                   check_en_q;
  logic                   inject_q;
  logic                   err_flag_q;
  logic                   alert_flag_q;
  logic                   hit;
  logic                   wr_en;

  //////////////////////////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////////////////////////

  assign hit = (paddr_i == `PC_GUARD_REG_CTRL)   || (paddr_i == `PC_GUARD_REG_BOOT)  ||
               (paddr_i == `PC_GUARD_REG_TRAP)   || (paddr_i == `PC_GUARD_REG_THRESH) ||
               (paddr_i == `PC_GUARD_REG_COUNT)  || (paddr_i == `PC_GUARD_REG_STATUS);

  // Zero wait state, access phase completes every transfer
  assign wr_en     = psel_i && penable_i && pwrite_i && hit;
  assign pready_o  = 1'b1;
  assign pslverr_o = psel_i && penable_i && !hit;

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      boot_q       <= `PC_GUARD_BOOT_RST;
      trap_q       <= `PC_GUARD_TRAP_RST;
      thresh_q     <= `PC_GUARD_THRESH_RST;
      check_en_q   <= 1'b1;
      inject_q     <= 1'b0;
      err_flag_q   <= 1'b0;
      alert_flag_q <= 1'b0;
    end else begin
      // Inject is a one-cycle pulse, armed in the PC generator
      inject_q <= 1'b0;
      if (wr_en && (paddr_i == `PC_GUARD_REG_CTRL)) begin
        check_en_q <= pwdata_i[0];
        inject_q   <= pwdata_i[1];
      end
      if (wr_en && (paddr_i == `PC_GUARD_REG_BOOT)) begin
        boot_q <= pwdata_i;
      end
      if (wr_en && (paddr_i == `PC_GUARD_REG_TRAP)) begin
        trap_q <= pwdata_i;
      end
      if (wr_en && (paddr_i == `PC_GUARD_REG_THRESH)) begin
        thresh_q <= pwdata_i[`PC_GUARD_CNT_W-1:0];
      end
      // Sticky flags, new events win over write-1-to-clear
      if (pc_err_i) begin
        err_flag_q <= 1'b1;
      end else if (wr_en && (paddr_i == `PC_GUARD_REG_STATUS) && pwdata_i[0]) begin
        err_flag_q <= 1'b0;
      end
      if (alert_i) begin
        alert_flag_q <= 1'b1;
      end else if (wr_en && (paddr_i == `PC_GUARD_REG_STATUS) && pwdata_i[1]) begin
        alert_flag_q <= 1'b0;
      end
    end
  end

  // Any write to COUNT clears the counter
  assign count_clr_o = wr_en && (paddr_i == `PC_GUARD_REG_COUNT);

  //////////////////////////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    prdata_o = '0;
    if (psel_i) begin
      case (paddr_i)
        `PC_GUARD_REG_CTRL:   prdata_o = {30'd0, inject_q, check_en_q};
        `PC_GUARD_REG_BOOT:   prdata_o = boot_q;
        `PC_GUARD_REG_TRAP:   prdata_o = trap_q;
        `PC_GUARD_REG_THRESH: prdata_o = {{(`PC_GUARD_DATA_W-`PC_GUARD_CNT_W){1'b0}}, thresh_q};
        `PC_GUARD_REG_COUNT:  prdata_o = {{(`PC_GUARD_DATA_W-`PC_GUARD_CNT_W){1'b0}}, count_i};
        `PC_GUARD_REG_STATUS: prdata_o = {30'd0, alert_flag_q, err_flag_q};
        default:              prdata_o = '0;
      endcase
    end
  end

  assign boot_addr_o = boot_q;
  assign trap_addr_o = trap_q;
  assign thresh_o    = thresh_q;
  assign check_en_o  = check_en_q;
  assign inject_o    = inject_q;

endmodule

// File: rtl/pc_guard_pkg.sv
// PC guard shared types for addresses, counts, instruction kinds and FSM encodings
`include "pc_guard_consts.svh"

package pc_guard_pkg;

  // Program counter or any byte address
  typedef logic [`PC_GUARD_ADDR_W-1:0] pc_t;

  // Error count and alert threshold
  typedef logic [`PC_GUARD_CNT_W-1:0] err_cnt_t;

  // Kind of the instruction described by a stream descriptor
  typedef enum logic [1:0] {
    KIND_SEQ    = 2'd0,
    KIND_JUMP   = 2'd1,
    KIND_BRANCH = 2'd2
  } instr_kind_e;

  // PC source select on a PC set
  typedef enum logic [1:0] {
    PC_BOOT   = 2'd0,
    PC_JUMP   = 2'd1,
    PC_BRANCH = 2'd2,
    PC_TRAP   = 2'd3
  } pc_mux_e;

  // Controller states
  typedef enum logic [1:0] {
    ST_BOOT = 2'd0,
    ST_RUN  = 2'd1,
    ST_TRAP = 2'd2
  } fsm_state_e;

endpackage

// File: rtl/pc_guard_top.sv
// PC guard top level joining controller, PC generator, checker, error counter and APB block
`timescale 1ns/1ps
`include "pc_guard_consts.svh"

module pc_guard_top (
  input  logic                         clk,
  input  logic                         rst_n,
  // APB slave
  input  logic [`PC_GUARD_PADDR_W-1:0] paddr_i,
  input  logic                         psel_i,
  input  logic                         penable_i,
  input  logic                         pwrite_i,
  input  logic [`PC_GUARD_DATA_W-1:0]  pwdata_i,
  output logic [`PC_GUARD_DATA_W-1:0]  prdata_o,
  output logic                         pready_o,
  output logic                         pslverr_o,
  // Instruction descriptor stream
  input  logic                         instr_valid_i,
  input  pc_guard_pkg::instr_kind_e    instr_kind_i,
  input  logic                         instr_compressed_i,
  input  pc_guard_pkg::pc_t            instr_target_i,
  input  logic                         instr_taken_i,
  output logic                         instr_ready_o,
  // Fetch PC and alert
  output pc_guard_pkg::pc_t            pc_o,
  output logic                         alert_o
);

  logic                   pc_set;
  logic                   accept;
  pc_guard_pkg::pc_mux_e  pc_mux;
  logic                   pc_err;
  pc_guard_pkg::pc_t      boot_addr;
  pc_guard_pkg::pc_t      trap_addr;
  pc_guard_pkg::err_cnt_t thresh;
  pc_guard_pkg::err_cnt_t count;
  logic                   check_en;
  logic                   inject;
  logic                   count_clr;

  pc_ctrl_fsm pc_ctrl_fsm_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid_i (instr_valid_i),
    .instr_kind_i  (instr_kind_i),
    .instr_taken_i (instr_taken_i),
    .alert_i       (alert_o),
    .instr_ready_o (instr_ready_o),
    .accept_o      (accept),
    .pc_set_o      (pc_set),
    .pc_mux_o      (pc_mux)
  );

  pc_gen pc_gen_inst (
    .clk                (clk),
    .rst_n              (rst_n),
    .accept_i           (accept),
    .instr_compressed_i (instr_compressed_i),
    .pc_set_i           (pc_set),
    .pc_mux_i           (pc_mux),
    .instr_target_i     (instr_target_i),
    .boot_addr_i        (boot_addr),
    .trap_addr_i        (trap_addr),
    .inject_i           (inject),
    .pc_o               (pc_o)
  );

  // Reference block, sees the same request but recomputes on its own
  pc_check pc_check_inst (
    .clk                (clk),
    .rst_n              (rst_n),
    .check_en_i         (check_en),
    .accept_i           (accept),
    .instr_compressed_i (instr_compressed_i),
    .pc_set_i           (pc_set),
    .instr_kind_i       (instr_kind_i),
    .instr_taken_i      (instr_taken_i),
    .pc_mux_i           (pc_mux),
    .instr_target_i     (instr_target_i),
    .boot_addr_i        (boot_addr),
    .trap_addr_i        (trap_addr),
    .pc_i               (pc_o),
    .pc_err_o           (pc_err)
  );

  pc_err_counter pc_err_counter_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .pc_err_i (pc_err),
    .clr_i    (count_clr),
    .thresh_i (thresh),
    .count_o  (count),
    .alert_o  (alert_o)
  );

  pc_guard_apb pc_guard_apb_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .paddr_i     (paddr_i),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .pwdata_i    (pwdata_i),
    .prdata_o    (prdata_o),
    .pready_o    (pready_o),
    .pslverr_o   (pslverr_o),
    .count_i     (count),
    .pc_err_i    (pc_err),
    .alert_i     (alert_o),
    .boot_addr_o (boot_addr),
    .trap_addr_o (trap_addr),
    .thresh_o    (thresh),
    .check_en_o  (check_en),
    .inject_o    (inject),
    .count_clr_o (count_clr)
  );

endmodule

// File: tests/pc_guard_tb.sv
// Directed testbench for the PC guard covering PC flow, checker errors, trap and APB registers
`timescale 1ns/1ps
`include "pc_guard_consts.svh"

module pc_guard_tb;

  // Cycle budget of about 3 cycles per instruction and 4 per APB transfer
  localparam int NUM_INSTR  = 300;
  localparam int NUM_APB    = 45;
  localparam int RUN_CYCLES = 20 + 3 * NUM_INSTR + 4 * NUM_APB;
  localparam int MAX_CYCLES = 2 * RUN_CYCLES;

  logic                         clk;
  logic                         rst_n;
  logic [`PC_GUARD_PADDR_W-1:0] paddr;
  logic                         psel;
  logic                         penable;
  logic                         pwrite;
  logic [`PC_GUARD_DATA_W-1:0]  pwdata;
  logic [`PC_GUARD_DATA_W-1:0]  prdata;
  logic                         pready;
  logic                         pslverr;
  logic                         instr_valid;
  pc_guard_pkg::instr_kind_e    instr_kind;
  logic                         instr_compressed;
  pc_guard_pkg::pc_t            instr_target;
  logic                         instr_taken;
  logic                         instr_ready;
  pc_guard_pkg::pc_t            pc;
  logic                         alert;

  // Reference PC, LFSR state and cycle counter
  pc_guard_pkg::pc_t            model_pc;
  logic [31:0]                  lfsr_q;
  int                           cycle_count;

  tb_clk_gen tb_clk_gen_inst (
    .clk   (clk),
    .rst_n (rst_n)
  );

  pc_guard_top pc_guard_top_inst (
    .clk                (clk),
    .rst_n              (rst_n),
    .paddr_i            (paddr),
    .psel_i             (psel),
    .penable_i          (penable),
    .pwrite_i           (pwrite),
    .pwdata_i           (pwdata),
    .prdata_o           (prdata),
    .pready_o           (pready),
    .pslverr_o          (pslverr),
    .instr_valid_i      (instr_valid),
    .instr_kind_i       (instr_kind),
    .instr_compressed_i (instr_compressed),
    .instr_target_i     (instr_target),
    .instr_taken_i      (instr_taken),
    .instr_ready_o      (instr_ready),
    .pc_o               (pc),
    .alert_o            (alert)
  );

  //////////////////////////////////////////////////////////////////////
  // Failure reporting and compares
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic compare_pc(input string name, input pc_guard_pkg::pc_t got,
                            input pc_guard_pkg::pc_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic compare_count(input string name, input pc_guard_pkg::err_cnt_t got,
                               input pc_guard_pkg::err_cnt_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch %s: got 0x%02h, expected 0x%02h", name, got, exp));
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  // Run limit catches a stalled handshake anywhere
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > MAX_CYCLES) begin
      abort_run("Run exceeded its cycle limit without finishing the tests");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1 and one step per returned bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] bits;
    logic        fb;
    int          i;
    bits = '0;
    for (i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      bits   = {bits[30:0], fb};
    end
    return bits;
  endfunction

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    logic done;
    @(posedge clk);
    paddr   <= addr;
    pwdata  <= data;
    pwrite  <= 1'b1;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge clk);
    penable <= 1'b1;
    done = 1'b0;
    // Access phase ends on the edge that sees pready
    while (!done) begin
      @(negedge clk);
      done = pready;
      @(posedge clk);
    end
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic slverr);
    logic done;
    @(posedge clk);
    paddr   <= addr;
    pwrite  <= 1'b0;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge clk);
    penable <= 1'b1;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      done   = pready;
      data   = prdata;
      slverr = pslverr;
      @(posedge clk);
    end
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // Sends one descriptor and checks pc_o against the stepped model PC
  task automatic send_instr(input pc_guard_pkg::instr_kind_e kind, input logic compressed,
                            input pc_guard_pkg::pc_t target, input logic taken,
                            input logic corrupt);
    pc_guard_pkg::pc_t next_pc;
    logic              accepted;
    logic              redirect;
    redirect = (kind == pc_guard_pkg::KIND_JUMP) ||
               ((kind == pc_guard_pkg::KIND_BRANCH) && taken);
    @(posedge clk);
    instr_valid      <= 1'b1;
    instr_kind       <= kind;
    instr_compressed <= compressed;
    instr_target     <= target;
    instr_taken      <= taken;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = instr_ready;
      @(posedge clk);
    end
    instr_valid <= 1'b0;
    if (redirect) begin
      next_pc = {target[31:1], 1'b0};
    end else begin
      next_pc = model_pc + (compressed ? 32'd2 : 32'd4);
    end
    // Injected fault flips bit 1 of this one update
    if (corrupt) begin
      next_pc = next_pc ^ 32'h2;
    end
    model_pc = next_pc;
    @(negedge clk);
    compare_pc("pc_o", pc, model_pc);
  endtask

  task automatic sequential_run(input int n);
    logic [31:0] r;
    int          i;
    for (i = 0; i < n; i++) begin
      r = rand_bits(1);
      send_instr(pc_guard_pkg::KIND_SEQ, r[0], '0, 1'b0, 1'b0);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic register_access();
    logic [31:0] d;
    logic        e;
    apb_read(`PC_GUARD_REG_CTRL, d, e);
    compare_bit("ctrl.check_en", d[0], 1'b1);
    compare_bit("ctrl.inject", d[1], 1'b0);
    compare_bit("pslverr_o", e, 1'b0);
    apb_read(`PC_GUARD_REG_BOOT, d, e);
    compare_pc("boot", d, `PC_GUARD_BOOT_RST);
    apb_read(`PC_GUARD_REG_TRAP, d, e);
    compare_pc("trap", d, `PC_GUARD_TRAP_RST);
    apb_read(`PC_GUARD_REG_THRESH, d, e);
    compare_count("thresh", d[7:0], `PC_GUARD_THRESH_RST);
    apb_read(`PC_GUARD_REG_COUNT, d, e);
    compare_count("count", d[7:0], 8'd0);
    apb_read(`PC_GUARD_REG_STATUS, d, e);
    compare_bit("status.err", d[0], 1'b0);
    compare_bit("status.alert", d[1], 1'b0);
    // Offset past STATUS is unmapped
    apb_read(8'h18, d, e);
    compare_bit("pslverr_o", e, 1'b1);
    apb_write(`PC_GUARD_REG_BOOT, 32'h0000_1000);
    apb_write(`PC_GUARD_REG_TRAP, 32'h0000_2000);
    apb_write(`PC_GUARD_REG_THRESH, 32'h9);
    apb_read(`PC_GUARD_REG_BOOT, d, e);
    compare_pc("boot", d, 32'h0000_1000);
    apb_read(`PC_GUARD_REG_TRAP, d, e);
    compare_pc("trap", d, 32'h0000_2000);
    apb_read(`PC_GUARD_REG_THRESH, d, e);
    compare_count("thresh", d[7:0], 8'd9);
    // Back to reset values for the flow tests
    apb_write(`PC_GUARD_REG_BOOT, `PC_GUARD_BOOT_RST);
    apb_write(`PC_GUARD_REG_TRAP, `PC_GUARD_TRAP_RST);
    apb_write(`PC_GUARD_REG_THRESH, 32'(`PC_GUARD_THRESH_RST));
  endtask

  task automatic boot_and_seq_flow();
    logic [31:0] d;
    logic        e;
    logic        seen;
    int          i;
    seen = 1'b0;
    for (i = 0; (i < 8) && !seen; i++) begin
      @(negedge clk);
      seen = instr_ready;
    end
    if (!seen) begin
      abort_run("instr_ready_o never rose after reset");
    end
    compare_pc("pc_o", pc, `PC_GUARD_BOOT_RST);
    model_pc = `PC_GUARD_BOOT_RST;
    sequential_run(64);
    apb_read(`PC_GUARD_REG_COUNT, d, e);
    compare_count("count", d[7:0], 8'd0);
  endtask

  task automatic jump_branch_flow();
    logic [31:0]               r;
    pc_guard_pkg::instr_kind_e kind;
    logic                      compressed;
    logic                      taken;
    logic [31:0]               d;
    logic                      e;
    int                        i;
    for (i = 0; i < 200; i++) begin
      r          = rand_bits(1);
      kind       = r[0] ? pc_guard_pkg::KIND_JUMP : pc_guard_pkg::KIND_BRANCH;
      r          = rand_bits(1);
      compressed = r[0];
      r          = rand_bits(1);
      taken      = r[0];
      r          = rand_bits(31);
      send_instr(kind, compressed, {r[30:0], 1'b0}, taken, 1'b0);
    end
    apb_read(`PC_GUARD_REG_COUNT, d, e);
    compare_count("count", d[7:0], 8'd0);
    apb_read(`PC_GUARD_REG_STATUS, d, e);
    compare_bit("status.err", d[0], 1'b0);
    compare_bit("status.alert", d[1], 1'b0);
  endtask

  task automatic fault_injection();
    logic [31:0] d;
    logic        e;
    apb_write(`PC_GUARD_REG_CTRL, 32'h3);
    send_instr(pc_guard_pkg::KIND_SEQ, 1'b0, '0, 1'b0, 1'b1);
    // Checker follows the corrupted PC so no second error is counted
    send_instr(pc_guard_pkg::KIND_SEQ, 1'b1, '0, 1'b0, 1'b0);
    apb_read(`PC_GUARD_REG_COUNT, d, e);
    compare_count("count", d[7:0], 8'd1);
    apb_read(`PC_GUARD_REG_STATUS, d, e);
    compare_bit("status.err", d[0], 1'b1);
    compare_bit("status.alert", d[1], 1'b0);
    apb_read(`PC_GUARD_REG_CTRL, d, e);
    compare_bit("ctrl.inject", d[1], 1'b0);
    compare_bit("alert_o", alert, 1'b0);
    apb_write(`PC_GUARD_REG_COUNT, 32'h0);
    apb_read(`PC_GUARD_REG_COUNT, d, e);
    compare_count("count", d[7:0], 8'd0);
    apb_write(`PC_GUARD_REG_STATUS, 32'h3);
  endtask

  task automatic alert_and_trap();
    logic [31:0] d;
    logic        e;
    logic        seen;
    int          i;
    apb_write(`PC_GUARD_REG_THRESH, 32'h2);
    apb_write(`PC_GUARD_REG_CTRL, 32'h3);
    send_instr(pc_guard_pkg::KIND_SEQ, 1'b0, '0, 1'b0, 1'b1);
    apb_write(`PC_GUARD_REG_CTRL, 32'h3);
    send_instr(pc_guard_pkg::KIND_SEQ, 1'b1, '0, 1'b0, 1'b1);
    seen = 1'b0;
    for (i = 0; (i < 8) && !seen; i++) begin
      @(negedge clk);
      seen = alert;
    end
    if (!seen) begin
      abort_run("alert_o was not raised when the count reached the threshold");
    end
    // Alert is a one-cycle pulse and the trap address lands two cycles after it
    @(negedge clk);
    compare_bit("alert_o", alert, 1'b0);
    @(negedge clk);
    compare_pc("pc_o", pc, `PC_GUARD_TRAP_RST);
    model_pc = `PC_GUARD_TRAP_RST;
    apb_read(`PC_GUARD_REG_STATUS, d, e);
    compare_bit("status.alert", d[1], 1'b1);
    sequential_run(8);
    apb_read(`PC_GUARD_REG_COUNT, d, e);
    compare_count("count", d[7:0], 8'd2);
    // With checking off an injected fault goes uncounted
    apb_write(`PC_GUARD_REG_COUNT, 32'h0);
    apb_write(`PC_GUARD_REG_CTRL, 32'h2);
    send_instr(pc_guard_pkg::KIND_SEQ, 1'b0, '0, 1'b0, 1'b1);
    apb_read(`PC_GUARD_REG_COUNT, d, e);
    compare_count("count", d[7:0], 8'd0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    paddr            = '0;
    psel             = 1'b0;
    penable          = 1'b0;
    pwrite           = 1'b0;
    pwdata           = '0;
    instr_valid      = 1'b0;
    instr_kind       = pc_guard_pkg::KIND_SEQ;
    instr_compressed = 1'b0;
    instr_target     = '0;
    instr_taken      = 1'b0;
    model_pc         = '0;
    lfsr_q           = 32'hcc1dcdff;
    cycle_count      = 0;
    @(posedge rst_n);
    // Still in the boot state with quiet outputs
    compare_bit("instr_ready_o", instr_ready, 1'b0);
    compare_bit("alert_o", alert, 1'b0);
    compare_bit("pslverr_o", pslverr, 1'b0);
    register_access();
    boot_and_seq_flow();
    jump_branch_flow();
    fault_injection();
    alert_and_trap();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: tests/tb_clk_gen.sv
// Testbench clock and power-on reset source for the PC guard
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int HALF_PERIOD = 10,
  parameter int RST_CYCLES  = 5
) (
  output logic clk,
  output logic rst_n
);

  // 20 ns period free-running clock
  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Reset held over the first rising edges, released mid-cycle
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule
